// ==== rtl/dsp_pkg.sv ====
`default_nettype none

package dsp_pkg;

    localparam int LANES            = 4;
    localparam int CODE_W           = 8;
    localparam int FFE_TAPS         = 3;
    localparam int WEIGHT_W         = 8;
    localparam int CHAN_TAPS        = 3;
    localparam int CHAN_W           = 6;
    localparam int FFE_SHIFT        = 6;
    localparam int EQ_W             = 10;
    localparam int ERR_W            = 12;
    localparam int FIFO_DEPTH       = 4;
    localparam int OUT_CREDITS_INIT = 2;

    // derived widths
    localparam int PROD_W     = CODE_W + WEIGHT_W;
    localparam int SUM_W      = PROD_W + $clog2(FFE_TAPS);
    localparam int EQ_MAX     = 2 ** (EQ_W - 1) - 1;
    localparam int EQ_MIN     = -(2 ** (EQ_W - 1));
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);
    // one bit above the initial credit so a surplus return shows up
    localparam int CREDIT_W   = $clog2(OUT_CREDITS_INIT + 1) + 1;

    typedef logic signed [CODE_W-1:0]   code_t;
    typedef logic signed [WEIGHT_W-1:0] weight_t;
    typedef logic signed [CHAN_W-1:0]   chan_t;
    typedef logic signed [EQ_W-1:0]     eq_t;
    typedef logic signed [ERR_W-1:0]    err_t;
    typedef logic signed [PROD_W-1:0]   prod_t;
    typedef logic signed [SUM_W-1:0]    sum_t;

    // lane 0 is the oldest sample
    typedef code_t [LANES-1:0]     adc_word_t;
    typedef eq_t [LANES-1:0]       eq_word_t;
    typedef weight_t [FFE_TAPS-1:0] weights_t;
    typedef chan_t [CHAN_TAPS-1:0] chan_est_t;

    typedef struct packed {
        logic [LANES-1:0] decision;
        err_t [LANES-1:0] error;
    } result_t;

    typedef struct packed {
        weight_t weight;
    } ffe_coef_t;

    typedef struct packed {
        logic [1:0] rsvd;
        chan_t      tap;
    } chan_coef_t;

    typedef union packed {
        ffe_coef_t  ffe;
        chan_coef_t chan;
    } cfg_word_t;

    typedef enum logic [1:0] {
        IDLE,
        LOAD_FFE,
        LOAD_CHAN,
        RUN
    } load_state_t;

endpackage

`default_nettype wire

// ==== rtl/tap_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module tap_counter (
    input  logic       clk,
    input  logic       reset_i,
    input  logic       clear_i,
    input  logic       step_i,
    input  logic [1:0] last_count_i,
    output logic [1:0] count_o,
    output logic       last_o
);

    // flags the step that lands on the final tap of the group
    assign last_o = step_i && (count_o == last_count_i);

    always_ff @(posedge clk) begin
        if (reset_i || clear_i) begin
            count_o <= '0;
        end else if (step_i) begin
            if (last_o) begin
                count_o <= '0;
            end else begin
                count_o <= count_o + 2'd1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/coef_load_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module coef_load_fsm (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               cfg_valid_i,
    input  dsp_pkg::cfg_word_t cfg_word_i,
    output dsp_pkg::weights_t  weights_o,
    output dsp_pkg::chan_est_t chan_est_o,
    output logic               run_o
);

    import dsp_pkg::*;

    load_state_t state;
    load_state_t state_next;
    logic        load_step;
    logic        load_chan;
    logic [1:0]  tap_idx;
    logic [1:0]  tap_last_count;
    logic        tap_last;

    assign run_o          = (state == RUN);
    assign load_chan      = (state == LOAD_CHAN);
    assign load_step      = cfg_valid_i && !run_o;
    assign tap_last_count = load_chan ? 2'(CHAN_TAPS - 1) : 2'(FFE_TAPS - 1);

    tap_counter tap_counter_i (
        .clk          (clk),
        .reset_i      (reset_i),
        .clear_i      (run_o),
        .step_i       (load_step),
        .last_count_i (tap_last_count),
        .count_o      (tap_idx),
        .last_o       (tap_last)
    );

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (cfg_valid_i) begin
                    state_next = LOAD_FFE;
                end
            end
            LOAD_FFE: if (tap_last) state_next = LOAD_CHAN;
            LOAD_CHAN: if (tap_last) state_next = RUN;
            default: state_next = state;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // the reserved bits are dropped and the tap keeps its own sign
    always_ff @(posedge clk) begin
        if (load_step && !load_chan) begin
            weights_o[tap_idx] <= cfg_word_i.ffe.weight;
        end
        if (load_step && load_chan) begin
            chan_est_o[tap_idx] <= cfg_word_i.chan.tap;
        end
    end

    assert property (@(posedge clk) disable iff (reset_i) !(cfg_valid_i && run_o))
        else $error("configuration word arrived after the run started");

endmodule

`default_nettype wire

// ==== rtl/ffe_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module ffe_datapath (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               run_i,
    input  logic               adc_valid_i,
    input  dsp_pkg::adc_word_t adc_i,
    input  dsp_pkg::weights_t  weights_i,
    output logic               eq_valid_o,
    output dsp_pkg::eq_word_t  eq_o
);

    import dsp_pkg::*;

    logic                                   accept;
    code_t [FFE_TAPS-2:0]                   hist;
    code_t [LANES+FFE_TAPS-2:0]             x_ext;
    prod_t [LANES-1:0][FFE_TAPS-1:0]        prod_d;
    prod_t [LANES-1:0][FFE_TAPS-1:0]        prod_q;
    logic                                   prod_valid;
    sum_t [LANES-1:0]                       sum_d;
    sum_t [LANES-1:0]                       shifted_d;
    eq_word_t                               eq_d;

    assign accept = adc_valid_i && run_i;

    // previous word's tail sits below the current lanes
    assign x_ext = {adc_i, hist};

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            for (int k = 0; k < FFE_TAPS; k++) begin
                prod_d[i][k] = $signed(x_ext[i + FFE_TAPS - 1 - k]) * $signed(weights_i[k]);
            end
        end
    end

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            sum_d[i] = '0;
            for (int k = 0; k < FFE_TAPS; k++) begin
                sum_d[i] = $signed(sum_d[i]) + $signed(prod_q[i][k]);
            end
            shifted_d[i] = $signed(sum_d[i]) >>> FFE_SHIFT;
            // clip to the equalized range
            if ($signed(shifted_d[i]) > EQ_MAX) begin
                eq_d[i] = eq_t'(EQ_MAX);
            end else if ($signed(shifted_d[i]) < EQ_MIN) begin
                eq_d[i] = eq_t'(EQ_MIN);
            end else begin
                eq_d[i] = shifted_d[i][EQ_W-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            prod_q <= prod_d;
        end
        if (prod_valid) begin
            eq_o <= eq_d;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            hist       <= '0;
            prod_valid <= 1'b0;
            eq_valid_o <= 1'b0;
        end else begin
            if (accept) begin
                hist <= adc_i[LANES-1:LANES-FFE_TAPS+1];
            end
            prod_valid <= accept;
            eq_valid_o <= prod_valid;
        end
    end

    assert property (@(posedge clk) disable iff (reset_i) adc_valid_i |-> run_i)
        else $error("ADC word sent before coefficients were loaded");

endmodule

`default_nettype wire

// ==== rtl/decision_error_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module decision_error_unit (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               eq_valid_i,
    input  dsp_pkg::eq_word_t  eq_i,
    input  dsp_pkg::chan_est_t chan_est_i,
    output logic               res_valid_o,
    output dsp_pkg::result_t   res_o
);

    import dsp_pkg::*;

    logic [LANES-1:0]           dec_d;
    logic [CHAN_TAPS-2:0]       dec_hist;
    logic [LANES+CHAN_TAPS-2:0] dec_ext;
    err_t [LANES-1:0]           est_d;
    err_t [LANES-1:0]           err_d;

    // zero and above slice to +1
    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            dec_d[i] = ~eq_i[i][EQ_W-1];
        end
    end

    assign dec_ext = {dec_d, dec_hist};

    // channel estimate applied to the +1/-1 symbols, then removed from the sample
    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            est_d[i] = '0;
            for (int k = 0; k < CHAN_TAPS; k++) begin
                if (dec_ext[i + CHAN_TAPS - 1 - k]) begin
                    est_d[i] = $signed(est_d[i]) + $signed(chan_est_i[k]);
                end else begin
                    est_d[i] = $signed(est_d[i]) - $signed(chan_est_i[k]);
                end
            end
            err_d[i] = $signed(eq_i[i]) - $signed(est_d[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (eq_valid_i) begin
            res_o.decision <= dec_d;
            res_o.error    <= err_d;
        end
    end

    // history resets to -1 symbols
    always_ff @(posedge clk) begin
        if (reset_i) begin
            dec_hist    <= '0;
            res_valid_o <= 1'b0;
        end else begin
            if (eq_valid_i) begin
                dec_hist <= dec_d[LANES-1:LANES-CHAN_TAPS+1];
            end
            res_valid_o <= eq_valid_i;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/credit_out_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module credit_out_stage (
    input  logic             clk,
    input  logic             reset_i,
    input  logic             wr_valid_i,
    input  dsp_pkg::result_t wr_data_i,
    input  logic             out_credit_i,
    output logic             res_valid_o,
    output dsp_pkg::result_t res_o,
    output logic             in_credit_o
);

    import dsp_pkg::*;

    result_t               fifo_mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_CNT_W-1:0] fifo_cnt;
    logic [CREDIT_W-1:0]   credit_cnt;
    logic                  has_data;
    logic                  pop;
    result_t               head;

    assign has_data = (fifo_cnt != '0) || wr_valid_i;
    assign pop      = has_data && (credit_cnt != '0);
    // empty FIFO forwards the incoming result straight to the output register
    assign head     = (fifo_cnt == '0) ? wr_data_i : fifo_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_valid_i) begin
            fifo_mem[wr_ptr] <= wr_data_i;
        end
        if (pop) begin
            res_o <= head;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            fifo_cnt    <= '0;
            credit_cnt  <= CREDIT_W'(OUT_CREDITS_INIT);
            res_valid_o <= 1'b0;
            in_credit_o <= 1'b0;
        end else begin
            if (wr_valid_i) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            fifo_cnt    <= fifo_cnt + FIFO_CNT_W'(wr_valid_i) - FIFO_CNT_W'(pop);
            // spend and return may land in the same cycle
            credit_cnt  <= credit_cnt + CREDIT_W'(out_credit_i) - CREDIT_W'(pop);
            res_valid_o <= pop;
            in_credit_o <= pop;
        end
    end

    assert property (@(posedge clk) disable iff (reset_i)
        !(wr_valid_i && (fifo_cnt == FIFO_DEPTH)))
        else $error("result written into a full FIFO");

    assert property (@(posedge clk) disable iff (reset_i) credit_cnt <= OUT_CREDITS_INIT)
        else $error("downstream returned more credits than it was given");

endmodule

`default_nettype wire

// ==== rtl/dsp_rx_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module dsp_rx_top (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               cfg_valid_i,
    input  dsp_pkg::cfg_word_t cfg_word_i,
    input  logic               adc_valid_i,
    input  dsp_pkg::adc_word_t adc_i,
    input  logic               out_credit_i,
    output logic               run_o,
    output logic               in_credit_o,
    output logic               res_valid_o,
    output dsp_pkg::result_t   res_o
);

    import dsp_pkg::*;

    weights_t  weights;
    chan_est_t chan_est;
    logic      eq_valid;
    eq_word_t  eq_word;
    logic      dec_valid;
    result_t   dec_result;

    coef_load_fsm coef_load_fsm_i (
        .clk         (clk),
        .reset_i     (reset_i),
        .cfg_valid_i (cfg_valid_i),
        .cfg_word_i  (cfg_word_i),
        .weights_o   (weights),
        .chan_est_o  (chan_est),
        .run_o       (run_o)
    );

    ffe_datapath ffe_datapath_i (
        .clk         (clk),
        .reset_i     (reset_i),
        .run_i       (run_o),
        .adc_valid_i (adc_valid_i),
        .adc_i       (adc_i),
        .weights_i   (weights),
        .eq_valid_o  (eq_valid),
        .eq_o        (eq_word)
    );

    decision_error_unit decision_error_unit_i (
        .clk         (clk),
        .reset_i     (reset_i),
        .eq_valid_i  (eq_valid),
        .eq_i        (eq_word),
        .chan_est_i  (chan_est),
        .res_valid_o (dec_valid),
        .res_o       (dec_result)
    );

    // FIFO pops feed back to the ADC side as credits
    credit_out_stage credit_out_stage_i (
        .clk          (clk),
        .reset_i      (reset_i),
        .wr_valid_i   (dec_valid),
        .wr_data_i    (dec_result),
        .out_credit_i (out_credit_i),
        .res_valid_o  (res_valid_o),
        .res_o        (res_o),
        .in_credit_o  (in_credit_o)
    );

endmodule

`default_nettype wire

// ==== verification/dsp_rx_model.svh ====
`ifndef DSP_RX_MODEL_SVH
`define DSP_RX_MODEL_SVH

function automatic int clip_eq(input int v);
    if (v > EQ_MAX) return EQ_MAX;
    if (v < EQ_MIN) return EQ_MIN;
    return v;
endfunction

// sample sequence is the previous word's last two codes followed by the four lanes
function automatic eq_word_t ffe_word(input adc_word_t adc, input code_t prev_old,
                                      input code_t prev_new, input weights_t w);
    int       x [LANES+FFE_TAPS-1];
    int       acc;
    int       wk;
    eq_word_t eq;
    x[0] = $signed(prev_old);
    x[1] = $signed(prev_new);
    for (int i = 0; i < LANES; i++) begin
        x[i+FFE_TAPS-1] = $signed(adc[i]);
    end
    for (int i = 0; i < LANES; i++) begin
        acc = 0;
        for (int k = 0; k < FFE_TAPS; k++) begin
            wk = $signed(w[k]);
            acc = acc + wk * x[i+FFE_TAPS-1-k];
        end
        eq[i] = eq_t'(clip_eq(acc >>> FFE_SHIFT));
    end
    return eq;
endfunction

// prev_dec bit 0 is the older of the two earlier decisions
function automatic result_t slice_and_error(input eq_word_t eq, input logic [1:0] prev_dec,
                                            input chan_est_t c);
    int      sym [LANES+CHAN_TAPS-1];
    int      ev;
    int      ck;
    int      est;
    result_t r;
    sym[0] = prev_dec[0] ? 1 : -1;
    sym[1] = prev_dec[1] ? 1 : -1;
    for (int i = 0; i < LANES; i++) begin
        ev = $signed(eq[i]);
        r.decision[i] = (ev >= 0);
        sym[i+CHAN_TAPS-1] = (ev >= 0) ? 1 : -1;
    end
    for (int i = 0; i < LANES; i++) begin
        est = 0;
        for (int k = 0; k < CHAN_TAPS; k++) begin
            ck = $signed(c[k]);
            est = est + ck * sym[i+CHAN_TAPS-1-k];
        end
        ev = $signed(eq[i]);
        r.error[i] = err_t'(ev - est);
    end
    return r;
endfunction

`endif

// ==== verification/dsp_rx_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module dsp_rx_tb;

    import dsp_pkg::*;

    `include "dsp_rx_model.svh"

    logic      clk = 1'b0;
    logic      reset_i;
    logic      cfg_valid_i;
    cfg_word_t cfg_word_i;
    logic      adc_valid_i;
    adc_word_t adc_i;
    logic      out_credit_i;
    logic      run_o;
    logic      in_credit_o;
    logic      res_valid_o;
    result_t   res_o;

    integer    seed;
    bit        strong_codes;
    weights_t  w_exp;
    chan_est_t c_exp;
    code_t     hist_old;
    code_t     hist_new;
    logic [1:0] dec_hist;
    result_t   exp_q [$];
    int        up_credits;
    int        in_credits;
    int        sent;
    int        res_count;
    int        returned;

    dsp_rx_top dsp_rx_top_i (
        .clk          (clk),
        .reset_i      (reset_i),
        .cfg_valid_i  (cfg_valid_i),
        .cfg_word_i   (cfg_word_i),
        .adc_valid_i  (adc_valid_i),
        .adc_i        (adc_i),
        .out_credit_i (out_credit_i),
        .run_o        (run_o),
        .in_credit_o  (in_credit_o),
        .res_valid_o  (res_valid_o),
        .res_o        (res_o)
    );

    always #2 clk = ~clk;

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    // extreme codes are common in the saturation round
    function automatic code_t pick_code();
        int r;
        r = $random(seed);
        if (strong_codes ? (r[3:2] != 2'b00) : (r[3:2] == 2'b00)) begin
            return r[1] ? code_t'(127) : code_t'(-128);
        end
        return r[15:8];
    endfunction

    task automatic apply_reset();
        reset_i = 1'b1;
        cfg_valid_i = 1'b0;
        adc_valid_i = 1'b0;
        out_credit_i = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;
        check_value("run_o", run_o, 0);
        check_value("res_valid_o", res_valid_o, 0);
        check_value("in_credit_o", in_credit_o, 0);
        up_credits = FIFO_DEPTH;
        in_credits = 0;
        sent = 0;
        res_count = 0;
        returned = 0;
        hist_old = '0;
        hist_new = '0;
        dec_hist = '0;
        exp_q.delete();
    endtask

    // weights go first and channel tap 0 is always negative
    task automatic load_config();
        logic [7:0] word;
        for (int j = 0; j < FFE_TAPS + CHAN_TAPS; j++) begin
            word = $random(seed);
            if (j < FFE_TAPS && strong_codes) word[7:5] = 3'b011;
            if (j >= FFE_TAPS && (strong_codes || j == FFE_TAPS)) word[CHAN_W-1] = 1'b1;
            @(negedge clk);
            check_value("run_o", run_o, 0);
            cfg_valid_i = 1'b1;
            cfg_word_i = word;
            if (j < FFE_TAPS) w_exp[j] = word;
            else c_exp[j-FFE_TAPS] = word[CHAN_W-1:0];
        end
        @(negedge clk);
        cfg_valid_i = 1'b0;
        check_value("run_o", run_o, 1);
    endtask

    task automatic step_cycle(input bit may_send, input bit may_return);
        adc_word_t word;
        eq_word_t  eq;
        result_t   r;
        result_t   expected;
        @(negedge clk);
        if (in_credit_o) begin
            in_credits++;
            up_credits++;
            if (up_credits > FIFO_DEPTH) stop_with_failure("upstream credit returned twice");
        end
        if (res_valid_o) begin
            res_count++;
            if (res_count > OUT_CREDITS_INIT + returned) begin
                stop_with_failure("result sent without a downstream credit");
            end
            if (exp_q.size() == 0) stop_with_failure("result arrived with no word outstanding");
            expected = exp_q.pop_front();
            check_value("res_o", res_o, expected);
        end
        adc_valid_i = 1'b0;
        out_credit_i = 1'b0;
        if (may_send && up_credits > 0 && ($random(seed) % 4 != 0)) begin
            for (int i = 0; i < LANES; i++) word[i] = pick_code();
            eq = ffe_word(word, hist_old, hist_new, w_exp);
            r = slice_and_error(eq, dec_hist, c_exp);
            exp_q.push_back(r);
            hist_old = word[LANES-2];
            hist_new = word[LANES-1];
            dec_hist = r.decision[LANES-1:LANES-2];
            adc_i = word;
            adc_valid_i = 1'b1;
            up_credits--;
            sent++;
        end
        if (may_return && res_count > returned && ($random(seed) % 2 != 0)) begin
            out_credit_i = 1'b1;
            returned++;
        end
    endtask

    task automatic stream_words(input int count);
        int guard;
        guard = 0;
        while (sent < count / 2) begin
            step_cycle(1'b1, 1'b1);
            guard++;
            if (guard > 4000) stop_with_failure("first half of the ADC words was never sent");
        end
        // downstream stall fills the FIFO until upstream credits run out
        for (int c = 0; c < 40; c++) step_cycle(1'b1, 1'b0);
        guard = 0;
        while (sent < count) begin
            step_cycle(1'b1, 1'b1);
            guard++;
            if (guard > 4000) stop_with_failure("second half of the ADC words was never sent");
        end
        guard = 0;
        while (res_count < sent) begin
            step_cycle(1'b0, 1'b1);
            guard++;
            if (guard > 2000) stop_with_failure("results did not drain after the last word");
        end
        // a duplicated result would still show up in this quiet window
        for (int c = 0; c < 20; c++) step_cycle(1'b0, 1'b1);
        check_value("in_credit_o pulses", in_credits, res_count);
    endtask

    initial begin
        seed = 82164;
        reset_i = 1'b1;
        cfg_valid_i = 1'b0;
        cfg_word_i = '0;
        adc_valid_i = 1'b0;
        adc_i = '0;
        out_credit_i = 1'b0;
        for (int round = 0; round < 2; round++) begin
            strong_codes = (round == 1);
            apply_reset();
            load_config();
            stream_words(200);
        end
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+verification
rtl/dsp_pkg.sv
rtl/tap_counter.sv
rtl/coef_load_fsm.sv
rtl/ffe_datapath.sv
rtl/decision_error_unit.sv
rtl/credit_out_stage.sv
rtl/dsp_rx_top.sv
verification/dsp_rx_tb.sv

// ==== Bender.yml ====
package:
  name: dsp_rx

sources:
  - files:
      - rtl/dsp_pkg.sv
      - rtl/tap_counter.sv
      - rtl/coef_load_fsm.sv
      - rtl/ffe_datapath.sv
      - rtl/decision_error_unit.sv
      - rtl/credit_out_stage.sv
      - rtl/dsp_rx_top.sv
  - target: simulation
    include_dirs:
      - verification
    files:
      - verification/dsp_rx_tb.sv
